// ==== rtl/spi_ctl_pkg.sv ====
/*
  spi board-control package
  frame geometry, register map and reset values shared by the
  slave, the register bank and the top level
*/

package spi_ctl_pkg;

  ////////////////////////////////////////////////////////////
  // frame geometry

  // one spi frame, msb first
  localparam int frame_bits = 16;

  // first byte is the register address, the rest is data
  localparam int addr_bits = 8;

  // width of each control register
  // data byte carries clear bits high, set bits low
  localparam int ctl_bits = 4;

  ////////////////////////////////////////////////////////////
  // register map

  // set/clear/toggle registers
  localparam logic [addr_bits-1:0] addr_led = 8'd7;
  localparam logic [addr_bits-1:0] addr_dac = 8'd9;
  localparam logic [addr_bits-1:0] addr_adc = 8'd14;

  // peripheral select index, low data nibble
  localparam logic [addr_bits-1:0] addr_spi_sel = 8'd8;

  // commands, data byte ignored
  localparam logic [addr_bits-1:0] addr_soft_rst = 8'd11;
  localparam logic [addr_bits-1:0] addr_pwr_clr  = 8'd6;

  ////////////////////////////////////////////////////////////
  // reset values

  // dac control lines idle high after rst
  localparam logic [ctl_bits-1:0] dac_rst_val = 4'b1111;

endpackage

// ==== rtl/spi_frame_slave.sv ====
/*
  spi frame slave
  synchronizes the spi pins into clk, shifts 16-bit frames in,
  shifts the addressed register back out and strobes a full frame
*/

module spi_frame_slave (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  sclk,
  input  logic                                                  cs_n,
  input  logic                                                  mosi,
  input  logic [spi_ctl_pkg::frame_bits-spi_ctl_pkg::addr_bits-1:0] rd_data,
  output logic [spi_ctl_pkg::addr_bits-1:0]                     rd_addr,
  output logic [spi_ctl_pkg::addr_bits-1:0]                     frame_addr,
  output logic [spi_ctl_pkg::frame_bits-spi_ctl_pkg::addr_bits-1:0] frame_data,
  output logic                                                  frame_valid,
  output logic                                                  slave_dout
);

  localparam int frame_bits = spi_ctl_pkg::frame_bits;
  localparam int addr_bits  = spi_ctl_pkg::addr_bits;
  localparam int data_bits  = frame_bits - addr_bits;

  // two-flop synchronizers, bit 1 is the usable copy
  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;

  // delayed copies for edge detect
  logic sclk_d;
  logic cs_d;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;
  logic frame_done;

  // bit count saturates at frame_bits + 1
  logic [4:0]                 bit_cnt;
  logic                       addr_done;
  logic [frame_bits-1:0]      shift_in;
  logic [data_bits-1:0]       dout_sr;

  ////////////////////////////////////////////////////////////
  // pin synchronization and edge detect

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // idle bus, cs high and sclk low
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_d    <= sclk_sync[1];
      cs_d      <= cs_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_d;
  assign sclk_fall = ~sclk_sync[1] & sclk_d;
  assign cs_rise   = cs_sync[1] & ~cs_d;

  // commit only on exactly 16 bits
  assign frame_done = cs_rise && (bit_cnt == 5'(frame_bits));

  ////////////////////////////////////////////////////////////
  // bit counter and strobes

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bit_cnt     <= '0;
      addr_done   <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= frame_done;
      if (cs_sync[1])
      begin
        // deselected, hold clear
        bit_cnt   <= '0;
        addr_done <= 1'b0;
      end
      else
      begin
        // one cycle after the 8th rising edge
        addr_done <= sclk_rise && (bit_cnt == 5'(addr_bits - 1));
        if (sclk_rise && (bit_cnt != 5'(frame_bits + 1)))
          bit_cnt <= bit_cnt + 5'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // shifters

  always_ff @(posedge clk)
  begin
    if (rst || cs_sync[1])
    begin
      shift_in   <= '0;
      dout_sr    <= '0;
      slave_dout <= 1'b0;
    end
    else
    begin
      // capture on rising sclk, msb first
      if (sclk_rise)
        shift_in <= {shift_in[frame_bits-2:0], mosi_sync[1]};

      // readback loaded after the address byte
      // shifted out on falling sclk
      if (addr_done)
        dout_sr <= rd_data;
      else if (sclk_fall)
      begin
        slave_dout <= dout_sr[data_bits-1];
        dout_sr    <= {dout_sr[data_bits-2:0], 1'b0};
      end
    end
  end

  // address byte sits in the low bits once 8 bits are in
  assign rd_addr = shift_in[addr_bits-1:0];

  // frame payload held for the register bank
  always_ff @(posedge clk)
  begin
    if (frame_done)
    begin
      frame_addr <= shift_in[frame_bits-1:data_bits];
      frame_data <= shift_in[data_bits-1:0];
    end
  end

  // one strobe per cs rise
  a_valid_single : assert property (@(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid);

endmodule

// ==== rtl/ctl_register_bank.sv ====
/*
  board control register bank
  decodes committed spi frames into set/clear/toggle writes,
  soft reset and power-up clear, and serves readback values
*/

module ctl_register_bank #(
  parameter int NUM_PERIPH = 5
) (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic [spi_ctl_pkg::addr_bits-1:0]                     frame_addr,
  input  logic [spi_ctl_pkg::frame_bits-spi_ctl_pkg::addr_bits-1:0] frame_data,
  input  logic                                                  frame_valid,
  input  logic [spi_ctl_pkg::addr_bits-1:0]                     rd_addr,
  output logic [spi_ctl_pkg::frame_bits-spi_ctl_pkg::addr_bits-1:0] rd_data,
  output logic [spi_ctl_pkg::ctl_bits-1:0]                      led,
  output logic [spi_ctl_pkg::ctl_bits-1:0]                      dac_ctl,
  output logic [spi_ctl_pkg::ctl_bits-1:0]                      adc_ctl,
  output logic [3:0]                                            spi_sel
);

  localparam int ctl_bits  = spi_ctl_pkg::ctl_bits;
  localparam int data_bits = spi_ctl_pkg::frame_bits - spi_ctl_pkg::addr_bits;

  logic [ctl_bits-1:0] set_bits;
  logic [ctl_bits-1:0] clr_bits;

  // set bits low nibble, clear bits high nibble
  assign set_bits = frame_data[ctl_bits-1:0];
  assign clr_bits = frame_data[2*ctl_bits-1:ctl_bits];

  // per bit: set alone -> 1, clear alone -> 0
  // both -> toggle, neither -> keep
  function automatic logic [ctl_bits-1:0] apply_set_clr(
    input logic [ctl_bits-1:0] cur,
    input logic [ctl_bits-1:0] set,
    input logic [ctl_bits-1:0] clr
  );
    logic [ctl_bits-1:0] keep;
    logic [ctl_bits-1:0] tog;
    keep = cur & ~(set | clr);
    tog  = ~cur & set & clr;
    return keep | (set & ~clr) | tog;
  endfunction

  ////////////////////////////////////////////////////////////
  // register writes

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led     <= '0;
      dac_ctl <= spi_ctl_pkg::dac_rst_val;
      adc_ctl <= '0;
      spi_sel <= '0;
    end
    else if (frame_valid)
    begin
      case (frame_addr)
        spi_ctl_pkg::addr_led: led     <= apply_set_clr(led, set_bits, clr_bits);
        spi_ctl_pkg::addr_dac: dac_ctl <= apply_set_clr(dac_ctl, set_bits, clr_bits);
        spi_ctl_pkg::addr_adc: adc_ctl <= apply_set_clr(adc_ctl, set_bits, clr_bits);

        // out of range index parks the mux
        spi_ctl_pkg::addr_spi_sel:
        begin
          if (int'(frame_data[3:0]) > NUM_PERIPH)
            spi_sel <= '0;
          else
            spi_sel <= frame_data[3:0];
        end

        // soft reset clears everything, dac included
        spi_ctl_pkg::addr_soft_rst:
        begin
          led     <= '0;
          dac_ctl <= '0;
          adc_ctl <= '0;
          spi_sel <= '0;
        end

        // rails coming up, dac already configured
        spi_ctl_pkg::addr_pwr_clr:
        begin
          led     <= '0;
          adc_ctl <= '0;
        end

        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback, zero extended

  always_comb
  begin
    rd_data = '0;
    case (rd_addr)
      spi_ctl_pkg::addr_led:     rd_data = data_bits'(led);
      spi_ctl_pkg::addr_spi_sel: rd_data = data_bits'(spi_sel);
      spi_ctl_pkg::addr_dac:     rd_data = data_bits'(dac_ctl);
      spi_ctl_pkg::addr_adc:     rd_data = data_bits'(adc_ctl);
      default:                   rd_data = '0;
    endcase
  end

  // mux decode relies on a valid index
  a_sel_range : assert property (@(posedge clk) disable iff (rst)
    int'(spi_sel) <= NUM_PERIPH);

endmodule

// ==== rtl/spi_periph_mux.sv ====
/*
  spi peripheral mux
  fans cs2_n out to one peripheral chip select and picks miso
*/

module spi_periph_mux #(
  parameter int NUM_PERIPH = 5
) (
  input  logic                  cs2_n,
  input  logic [3:0]            spi_sel,
  input  logic                  slave_dout,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  output logic                  miso,
  output logic [NUM_PERIPH-1:0] periph_cs_n
);

  always_comb
  begin
    // cs2 idle, the register slave owns miso
    periph_cs_n = '1;
    miso        = slave_dout;
    if (!cs2_n)
    begin
      // index 0 selects nobody
      miso = 1'b0;
      for (int i = 0; i < NUM_PERIPH; i++)
      begin
        // index n maps to peripheral n-1
        if (spi_sel == 4'(i + 1))
        begin
          periph_cs_n[i] = 1'b0;
          miso           = periph_miso[i];
        end
      end
    end
  end

  // never two peripherals on the bus
  always_comb
  begin
    a_one_hot_cs : assert final ($countones(~periph_cs_n) <= 1);
  end

endmodule

// ==== rtl/spi_ctl_top.sv ====
/*
  spi board-control top level
  register slave, control registers and peripheral spi mux
*/

module spi_ctl_top #(
  parameter int NUM_PERIPH = 5
) (
  input  logic                                clk,
  input  logic                                rst,

  // spi slave port
  input  logic                                sclk,
  input  logic                                cs_n,
  input  logic                                mosi,
  input  logic                                cs2_n,
  output logic                                miso,

  // muxed peripherals
  output logic [NUM_PERIPH-1:0]               periph_cs_n,
  input  logic [NUM_PERIPH-1:0]               periph_miso,

  // control lines
  output logic [spi_ctl_pkg::ctl_bits-1:0]    led,
  output logic [spi_ctl_pkg::ctl_bits-1:0]    dac_ctl,
  output logic [spi_ctl_pkg::ctl_bits-1:0]    adc_ctl,

  // adc data ready to host
  input  logic                                drdy_n,
  output logic                                irq_n
);

  localparam int addr_bits = spi_ctl_pkg::addr_bits;
  localparam int data_bits = spi_ctl_pkg::frame_bits - spi_ctl_pkg::addr_bits;

  ////////////////////////////////////////////////////////////
  // internal nets

  logic [addr_bits-1:0] rd_addr;
  logic [data_bits-1:0] rd_data;
  logic [addr_bits-1:0] frame_addr;
  logic [data_bits-1:0] frame_data;
  logic                 frame_valid;
  logic                 slave_dout;
  logic [3:0]           spi_sel;

  spi_frame_slave u_slave (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .frame_valid (frame_valid),
    .slave_dout  (slave_dout)
  );

  ctl_register_bank #(.NUM_PERIPH(NUM_PERIPH)) u_regs (
    .clk         (clk),
    .rst         (rst),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl),
    .spi_sel     (spi_sel)
  );

  spi_periph_mux #(.NUM_PERIPH(NUM_PERIPH)) u_mux (
    .cs2_n       (cs2_n),
    .spi_sel     (spi_sel),
    .slave_dout  (slave_dout),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n)
  );

  // single interrupt source, straight through
  assign irq_n = drdy_n;

endmodule

// ==== verif/tb_spi_ctl.sv ====
/*
  spi board-control testbench
  drives register frames over spi, models the register bank and
  checks control outputs, readback, framing and the peripheral mux
*/

module tb_spi_ctl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_periph  = 5;
  localparam int ctl_bits    = spi_ctl_pkg::ctl_bits;
  localparam int drive_delay = 10;
  // sclk half period in clk cycles
  localparam int half_clks   = 8;
  // roughly 80 frames of ~280 cycles each so the budget keeps margin
  localparam int frame_cycles = 300;
  localparam int frame_budget = 120;
  localparam int max_cycles   = frame_budget * frame_cycles;

  logic                  clk;
  logic                  rst;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  cs2_n;
  logic                  miso;
  logic [num_periph-1:0] periph_cs_n;
  logic [num_periph-1:0] periph_miso;
  logic [ctl_bits-1:0]   led;
  logic [ctl_bits-1:0]   dac_ctl;
  logic [ctl_bits-1:0]   adc_ctl;
  logic                  drdy_n;
  logic                  irq_n;

  // shadow registers of the model
  logic [ctl_bits-1:0] ref_led;
  logic [ctl_bits-1:0] ref_dac;
  logic [ctl_bits-1:0] ref_adc;
  logic [3:0]          ref_sel;

  logic cmp_req;
  int   err_count = 0;
  int   n_checks  = 0;
  int   cycle_cnt = 0;

  spi_ctl_top #(.NUM_PERIPH(num_periph)) u_dut (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl),
    .drdy_n      (drdy_n),
    .irq_n       (irq_n)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model

  // each bit set alone goes 1, clear alone 0, both toggle
  function automatic logic [ctl_bits-1:0] ctl_update(input logic [ctl_bits-1:0] cur,
                                                     input logic [7:0] data);
    logic [ctl_bits-1:0] nxt;
    for (int b = 0; b < ctl_bits; b++)
    begin
      case ({data[b+ctl_bits], data[b]})
        2'b01:   nxt[b] = 1'b1;
        2'b10:   nxt[b] = 1'b0;
        2'b11:   nxt[b] = ~cur[b];
        default: nxt[b] = cur[b];
      endcase
    end
    return nxt;
  endfunction

  // returns readback of the old value, then applies the write
  function automatic logic [7:0] ref_update(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] prev;
    prev = 8'h00;
    case (addr)
      spi_ctl_pkg::addr_led:     prev = 8'(ref_led);
      spi_ctl_pkg::addr_dac:     prev = 8'(ref_dac);
      spi_ctl_pkg::addr_adc:     prev = 8'(ref_adc);
      spi_ctl_pkg::addr_spi_sel: prev = 8'(ref_sel);
      default:                   prev = 8'h00;
    endcase
    case (addr)
      spi_ctl_pkg::addr_led: ref_led = ctl_update(ref_led, data);
      spi_ctl_pkg::addr_dac: ref_dac = ctl_update(ref_dac, data);
      spi_ctl_pkg::addr_adc: ref_adc = ctl_update(ref_adc, data);
      // index beyond the last peripheral parks at 0
      spi_ctl_pkg::addr_spi_sel: ref_sel = (int'(data[3:0]) > num_periph) ? 4'h0 : data[3:0];
      spi_ctl_pkg::addr_soft_rst:
      begin
        ref_led = '0;
        ref_dac = '0;
        ref_adc = '0;
        ref_sel = '0;
      end
      spi_ctl_pkg::addr_pwr_clr:
      begin
        ref_led = '0;
        ref_adc = '0;
      end
      default: ;
    endcase
    return prev;
  endfunction

  // expected peripheral chip selects
  function automatic logic [num_periph-1:0] expect_cs(input logic [3:0] sel, input logic cs2);
    logic [num_periph-1:0] cs;
    cs = '1;
    if (!cs2 && sel != 4'd0 && int'(sel) <= num_periph)
      cs = ~(num_periph'(1) << (int'(sel) - 1));
    return cs;
  endfunction

  // idle slave drives zero, sel 0 gives zero
  function automatic logic expect_miso(input logic [3:0] sel, input logic cs2,
                                       input logic [num_periph-1:0] pmiso);
    logic [num_periph-1:0] bits;
    bits = '0;
    if (!cs2 && sel != 4'd0 && int'(sel) <= num_periph)
      bits = pmiso >> (int'(sel) - 1);
    return bits[0];
  endfunction

  ////////////////////////////////////////////////////////////
  // checking

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk)
  begin
    if (cmp_req)
    begin
      check_val("led", 32'(led), 32'(ref_led));
      check_val("dac_ctl", 32'(dac_ctl), 32'(ref_dac));
      check_val("adc_ctl", 32'(adc_ctl), 32'(ref_adc));
      check_val("periph_cs_n", 32'(periph_cs_n), 32'(expect_cs(ref_sel, cs2_n)));
      check_val("miso", 32'(miso), 32'(expect_miso(ref_sel, cs2_n, periph_miso)));
      check_val("irq_n", 32'(irq_n), 32'(drdy_n));
    end
  end

  initial
  begin
    while (cycle_cnt < max_cycles)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the test sequence did not finish within %0d cycles", max_cycles);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #drive_delay;
  endtask

  task automatic request_compare();
    cmp_req = 1'b1;
    wait_clocks(1);
    cmp_req = 1'b0;
  endtask

  // msb first with miso sampled just before each rising sclk
  task automatic spi_frame(input logic [31:0] word, input int nbits, output logic [7:0] rb);
    logic [31:0] samples;
    samples = '0;
    cs_n = 1'b0;
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi = word[i];
      wait_clocks(half_clks);
      samples = {samples[30:0], miso};
      sclk = 1'b1;
      wait_clocks(half_clks);
      sclk = 1'b0;
    end
    wait_clocks(half_clks);
    cs_n = 1'b1;
    mosi = 1'b0;
    // data byte is the last 8 samples
    rb = samples[7:0];
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] exp_rb;
    logic [7:0] rb;
    exp_rb = ref_update(addr, data);
    spi_frame({16'h0, addr, data}, 16, rb);
    check_val("miso readback", 32'(rb), 32'(exp_rb));
    wait_clocks(8);
    request_compare();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [7:0] rb;
    logic [7:0] addr;
    rst         = 1'b1;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = '0;
    drdy_n      = 1'b1;
    cmp_req     = 1'b0;
    ref_led     = '0;
    ref_dac     = spi_ctl_pkg::dac_rst_val;
    ref_adc     = '0;
    ref_sel     = '0;
    void'($urandom(32'h7dc));

    wait_clocks(10);
    rst = 1'b0;
    wait_clocks(4);

    // reset values, interrupt path, idle mux
    request_compare();
    drdy_n = 1'b0;
    request_compare();
    drdy_n = 1'b1;
    cs2_n = 1'b0;
    request_compare();
    cs2_n = 1'b1;
    request_compare();

    // random set/clear/toggle on the three control registers
    repeat (60)
    begin
      case ($urandom % 3)
        0:       addr = spi_ctl_pkg::addr_led;
        1:       addr = spi_ctl_pkg::addr_dac;
        default: addr = spi_ctl_pkg::addr_adc;
      endcase
      write_reg(addr, 8'($urandom));
    end

    // unknown addresses read zero and write nothing
    write_reg(8'd3, 8'hff);
    write_reg(8'd200, 8'h0f);

    // short and long frames must not commit
    // the last bits shifted in would toggle every led bit if committed
    spi_frame({20'h0, 4'(spi_ctl_pkg::addr_led), 8'hff}, 12, rb);
    wait_clocks(8);
    request_compare();
    spi_frame({15'h0, 1'b1, spi_ctl_pkg::addr_led, 8'hff}, 17, rb);
    wait_clocks(8);
    request_compare();

    // soft reset clears all four
    write_reg(spi_ctl_pkg::addr_led, 8'h05);
    write_reg(spi_ctl_pkg::addr_dac, 8'h03);
    write_reg(spi_ctl_pkg::addr_adc, 8'h0a);
    write_reg(spi_ctl_pkg::addr_spi_sel, 8'h03);
    write_reg(spi_ctl_pkg::addr_soft_rst, 8'h00);

    // power-up clear keeps dac and select
    write_reg(spi_ctl_pkg::addr_led, 8'h0f);
    write_reg(spi_ctl_pkg::addr_dac, 8'h06);
    write_reg(spi_ctl_pkg::addr_adc, 8'h09);
    write_reg(spi_ctl_pkg::addr_spi_sel, 8'h04);
    write_reg(spi_ctl_pkg::addr_pwr_clr, 8'h00);

    // mux sweep where index 6 is out of range
    for (int n = 0; n <= 6; n++)
    begin
      write_reg(spi_ctl_pkg::addr_spi_sel, {4'($urandom), 4'(n)});
      cs2_n = 1'b0;
      repeat (4)
      begin
        periph_miso = num_periph'($urandom);
        request_compare();
      end
      cs2_n = 1'b1;
      request_compare();
    end

    wait_clocks(4);
    $display("checks: %0d, errors: %0d", n_checks, err_count);
    if (err_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/spi_ctl_pkg.sv
rtl/spi_frame_slave.sv
rtl/ctl_register_bank.sv
rtl/spi_periph_mux.sv
rtl/spi_ctl_top.sv
verif/tb_spi_ctl.sv

// ==== Makefile ====
# Verilator build and run of the spi board-control testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_ctl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -F -q -- '** PASS **' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
